/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rv_core
FILELIST  := src.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* core_pkg.sv */
package core_pkg;

  import rv_isa_pkg::*;

  // wishbone classic, master side
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // writeback source
  typedef enum logic [1:0] {
    WB_ALU, WB_MEM, WB_LINK, WB_NONE
  } wb_sel_e;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_out_t;

  typedef struct packed {
    addr_t    pc;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rd;
    alu_op_e  alu_op;
    logic     b_imm;    // operand b from imm
    logic     branch;
    logic     jal;
    logic     jalr;
    logic     lui;
    logic     auipc;
    logic     load;
    logic     store;
    logic     halt;
    funct3_t  funct3;
    wb_sel_e  wb_sel;
  } decode_out_t;

  typedef struct packed {
    word_t    result;     // alu value or data address
    word_t    store_data;
    reg_idx_t rd;
    wb_sel_e  wb_sel;
    logic     load;
    logic     store;
    logic     halt;
    word_t    link;
    addr_t    next_pc;
  } exec_out_t;

  typedef struct packed {
    addr_t pc;
    logic  halt;
  } retire_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } rf_write_t;

endpackage

/* decode_stage.sv */
module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::fetch_out_t  fetch_out,
  input  logic                  f_valid,
  input  core_pkg::rf_write_t   rf_write,
  output core_pkg::decode_out_t decode_out,
  output logic                  d_valid
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  inst_t       inst;
  opcode_e     opcode;
  funct3_t     funct3;
  funct7_t     funct7;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_u;
  word_t       imm_j;
  word_t       rs1_data;
  word_t       rs2_data;
  decode_out_t dec;

  assign inst   = f_valid ? fetch_out.inst : NOP_INST; // nop while nothing arrives
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  register_file u_regs (
    .clk      (clk),
    .rs1      (inst[19:15]),
    .rs2      (inst[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rf_write (rf_write)
  );

  // alt picks sub / sra
  function automatic alu_op_e alu_decode(funct3_t f3, logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec          = '0;
    dec.pc       = fetch_out.pc;
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    dec.rd       = inst[11:7];
    dec.funct3   = funct3;
    dec.imm      = imm_i;
    dec.alu_op   = ALU_ADD; // address and link math
    dec.wb_sel   = WB_NONE;
    case (opcode)
      OP: begin
        dec.alu_op = alu_decode(funct3, funct7[5]);
        dec.wb_sel = WB_ALU;
      end
      OP_IMM: begin
        dec.alu_op = alu_decode(funct3, funct7[5] && funct3 == F3_SR); // no subi
        dec.b_imm  = 1'b1;
        dec.wb_sel = WB_ALU;
        if (funct3 == F3_SLL || funct3 == F3_SR) begin
          dec.imm = {27'd0, inst[24:20]}; // shamt
        end
      end
      LOAD: begin
        dec.load   = 1'b1;
        dec.b_imm  = 1'b1;
        dec.wb_sel = WB_MEM;
      end
      STORE: begin
        dec.store = 1'b1;
        dec.b_imm = 1'b1;
        dec.imm   = imm_s;
      end
      BRANCH: begin
        dec.branch = 1'b1;
        dec.imm    = imm_b;
      end
      JAL: begin
        dec.jal    = 1'b1;
        dec.imm    = imm_j;
        dec.wb_sel = WB_LINK;
      end
      JALR: begin
        dec.jalr   = 1'b1;
        dec.b_imm  = 1'b1;
        dec.wb_sel = WB_LINK;
      end
      LUI: begin
        dec.lui    = 1'b1;
        dec.imm    = imm_u;
        dec.wb_sel = WB_ALU;
      end
      AUIPC: begin
        dec.auipc  = 1'b1;
        dec.imm    = imm_u;
        dec.wb_sel = WB_ALU;
      end
      SYSTEM: dec.halt = (inst == EBREAK_INST); // other system ops do nothing
      default: ; // unknown, retires as a nop
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (f_valid) begin
      decode_out <= dec;
    end
  end

endmodule

/* execute_stage.sv */
module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::decode_out_t decode_out,
  input  logic                  d_valid,
  output core_pkg::exec_out_t   exec_out,
  output logic                  e_valid
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  word_t       op_a;
  word_t       op_b;
  word_t       alu_res;
  word_t       pc_imm;
  word_t       link;
  logic [32:0] diff;
  logic        eq;
  logic        lt;
  logic        ltu;
  logic        taken;
  exec_out_t   ex;

  assign op_a = decode_out.rs1_data;
  assign op_b = decode_out.b_imm ? decode_out.imm : decode_out.rs2_data;

  // one subtract serves sub, slt and the branch compare
  assign diff = {1'b0, op_a} - {1'b0, op_b};
  assign eq   = (diff[31:0] == 32'd0);
  assign ltu  = diff[32]; // borrow out
  assign lt   = (op_a[31] ^ op_b[31]) ? op_a[31] : diff[31];

  always_comb begin
    case (decode_out.alu_op)
      ALU_SUB:  alu_res = diff[31:0];
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {31'd0, lt};
      ALU_SLTU: alu_res = {31'd0, ltu};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b; // ALU_ADD
    endcase
  end

  always_comb begin
    case (decode_out.funct3)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt;
      F3_BGE:  taken = !lt;
      F3_BLTU: taken = ltu;
      F3_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign pc_imm = decode_out.pc + decode_out.imm; // branch, jal and auipc
  assign link   = decode_out.pc + 32'd4;

  always_comb begin
    ex.store_data = decode_out.rs2_data;
    ex.rd         = decode_out.rd;
    ex.wb_sel     = decode_out.wb_sel;
    ex.load       = decode_out.load;
    ex.store      = decode_out.store;
    ex.halt       = decode_out.halt;
    ex.link       = link;

    if (decode_out.lui) begin
      ex.result = decode_out.imm;
    end else if (decode_out.auipc) begin
      ex.result = pc_imm;
    end else begin
      ex.result = alu_res;
    end

    if ((decode_out.branch && taken) || decode_out.jal) begin
      ex.next_pc = pc_imm;
    end else if (decode_out.jalr) begin
      ex.next_pc = {alu_res[31:1], 1'b0}; // rs1 + imm, bit 0 cleared
    end else begin
      ex.next_pc = link;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      e_valid <= 1'b0;
    end else begin
      e_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (d_valid) begin
      exec_out <= ex;
    end
  end

endmodule

/* fetch_stage.sv */
module fetch_stage #(
  parameter rv_isa_pkg::addr_t RESET_PC = 32'h8000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  output core_pkg::wb_req_t    ibus_req,
  input  core_pkg::wb_rsp_t    ibus_rsp,
  input  core_pkg::retire_t    retire,
  input  logic                 r_valid,
  output core_pkg::fetch_out_t fetch_out,
  output logic                 f_valid,
  output logic                 halted
);
  import rv_isa_pkg::*;

  typedef enum logic [1:0] {REQ, WAIT, IDLE, HALT} state_e;

  state_e state;
  addr_t  pc;
  logic   cyc;

  // read only, pc stays put while cyc is up
  assign ibus_req = '{cyc: cyc, stb: cyc, we: 1'b0, adr: pc, dat: '0};

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= REQ;
      pc      <= RESET_PC;
      cyc     <= 1'b0;
      f_valid <= 1'b0;
      halted  <= 1'b0;
    end else begin
      f_valid <= 1'b0;
      case (state)
        REQ: begin // first fetch out of reset
          cyc   <= 1'b1;
          state <= WAIT;
        end
        WAIT: begin
          if (ibus_rsp.ack) begin
            cyc     <= 1'b0;
            f_valid <= 1'b1;
            state   <= IDLE;
          end
        end
        IDLE: begin
          if (r_valid) begin
            if (retire.halt) begin
              state  <= HALT;
              halted <= 1'b1;
            end else begin
              pc    <= retire.pc;
              cyc   <= 1'b1; // next request right away
              state <= WAIT;
            end
          end
        end
        default: ; // HALT, only reset leaves it
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WAIT && ibus_rsp.ack) begin
      fetch_out <= '{pc: pc, inst: ibus_rsp.dat};
    end
  end

endmodule

/* mem_wb_stage.sv */
module mem_wb_stage (
  input  logic                clk,
  input  logic                rst,
  input  core_pkg::exec_out_t exec_out,
  input  logic                e_valid,
  output core_pkg::wb_req_t   dbus_req,
  input  core_pkg::wb_rsp_t   dbus_rsp,
  output core_pkg::rf_write_t rf_write,
  output core_pkg::retire_t   retire,
  output logic                r_valid
);
  import core_pkg::*;

  typedef enum logic [1:0] {IDLE, BUS, DONE} state_e;

  state_e    state;
  exec_out_t eo_q;
  exec_out_t rec;
  logic      wr_now;

  // word access only, held steady from eo_q until ack
  assign dbus_req = '{cyc: state == BUS, stb: state == BUS, we: eo_q.store,
                      adr: eo_q.result, dat: eo_q.store_data};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (e_valid) state <= (exec_out.load || exec_out.store) ? BUS : DONE;
        BUS:  if (dbus_rsp.ack) state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (e_valid) begin
      eo_q <= exec_out;
    end
  end

  // write lands on the edge that enters DONE
  assign rec    = (state == BUS) ? eo_q : exec_out;
  assign wr_now = (state == IDLE && e_valid && !exec_out.load && !exec_out.store) ||
                  (state == BUS && dbus_rsp.ack);

  always_comb begin
    rf_write.rd = rec.rd;
    case (rec.wb_sel)
      WB_ALU:  rf_write.data = rec.result;
      WB_MEM:  rf_write.data = dbus_rsp.dat;
      WB_LINK: rf_write.data = rec.link;
      default: rf_write.data = '0;
    endcase
    rf_write.we = wr_now && rec.rd != 5'd0 && rec.wb_sel != WB_NONE;
  end

  assign r_valid = (state == DONE);
  assign retire  = '{pc: eo_q.next_pc, halt: eo_q.halt};

endmodule

/* register_file.sv */
module register_file (
  input  logic                 clk,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data,
  input  core_pkg::rf_write_t  rf_write
);
  import rv_isa_pkg::*;

  word_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (rf_write.we && rf_write.rd != 5'd0) begin
      regs[rf_write.rd] <= rf_write.data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* rv_core_top.sv */
module rv_core_top #(
  parameter rv_isa_pkg::addr_t RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              rst,
  output core_pkg::wb_req_t ibus_req,
  input  core_pkg::wb_rsp_t ibus_rsp,
  output core_pkg::wb_req_t dbus_req,
  input  core_pkg::wb_rsp_t dbus_rsp,
  output logic              halted
);
  import core_pkg::*;

  fetch_out_t  f_out;
  logic        f_valid;
  decode_out_t d_out;
  logic        d_valid;
  exec_out_t   e_out;
  logic        e_valid;
  retire_t     ret;
  logic        r_valid;
  rf_write_t   rf_wr;   // mem_wb back into decode's register file

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk       (clk),
    .rst       (rst),
    .ibus_req  (ibus_req),
    .ibus_rsp  (ibus_rsp),
    .retire    (ret),
    .r_valid   (r_valid),
    .fetch_out (f_out),
    .f_valid   (f_valid),
    .halted    (halted)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .fetch_out  (f_out),
    .f_valid    (f_valid),
    .rf_write   (rf_wr),
    .decode_out (d_out),
    .d_valid    (d_valid)
  );

  execute_stage u_execute (
    .clk        (clk),
    .rst        (rst),
    .decode_out (d_out),
    .d_valid    (d_valid),
    .exec_out   (e_out),
    .e_valid    (e_valid)
  );

  mem_wb_stage u_mem_wb (
    .clk      (clk),
    .rst      (rst),
    .exec_out (e_out),
    .e_valid  (e_valid),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .rf_write (rf_wr),
    .retire   (ret),
    .r_valid  (r_valid)
  );

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b011_0011,
    OP_IMM = 7'b001_0011,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    BRANCH = 7'b110_0011,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 of OP / OP_IMM
  localparam funct3_t F3_ADD  = 3'b000; // add, sub, addi
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101; // srl and sra, split by funct7[5]
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // funct3 of BRANCH
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam inst_t NOP_INST    = 32'h0000_0013; // addi x0, x0, 0
  localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage

/* src.f */
rv_isa_pkg.sv
core_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
rv_core_top.sv
tb_rv_core.sv

/* tb_rv_core.sv */
module tb_rv_core;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam addr_t RESET_PC  = 32'h8000_0000;
  localparam int    MEM_WORDS = 1024;
  localparam int    RES_OFS   = 1024; // result area in bytes above RESET_PC
  localparam int    TIMEOUT   = 2000;

  logic    clk;
  logic    rst;
  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp;
  wb_req_t dbus_req;
  wb_rsp_t dbus_rsp;
  logic    halted;

  word_t       mem [MEM_WORDS];
  inst_t       prog [$];
  logic [31:0] lfsr;
  int          i_wait;
  int          d_wait;
  logic        i_busy;
  logic        d_busy;
  wb_req_t     d_held;    // dbus request as first seen
  int          dbus_acks;

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .halted   (halted)
  );

  always #5 clk = ~clk;

  task automatic report_fail();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_flag(string name, bit exp, logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      report_fail();
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_wait(output int n);
    logic [1:0] bits;
    lfsr    = lfsr_next(lfsr);
    bits[0] = lfsr[0];
    lfsr    = lfsr_next(lfsr);
    bits[1] = lfsr[0];
    n = int'(bits);
  endtask

  function automatic word_t fill_word(addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  task automatic mem_index(addr_t adr, output int idx);
    addr_t ofs;
    ofs = adr - RESET_PC;
    if (ofs[1:0] != 2'b00 || ofs >= addr_t'(4 * MEM_WORDS)) begin
      $display("bus access at %h is outside the memory model", adr);
      report_fail();
    end
    idx = int'(ofs >> 2);
  endtask

  // read-only instruction bus slave
  always @(posedge clk) begin
    int idx;
    #1;
    if (rst || ibus_rsp.ack) begin
      ibus_rsp.ack = 1'b0;
      i_busy       = 1'b0;
    end else if (ibus_req.cyc && ibus_req.stb) begin
      if (ibus_req.we) begin
        $display("write request seen on the instruction bus");
        report_fail();
      end
      if (!i_busy) begin
        i_busy = 1'b1;
        draw_wait(i_wait);
      end
      if (i_wait == 0) begin
        mem_index(ibus_req.adr, idx);
        ibus_rsp.dat = mem[idx];
        ibus_rsp.ack = 1'b1;
      end else begin
        i_wait--;
      end
    end
  end

  // data bus slave that also checks the request stays put until ack
  always @(posedge clk) begin
    int idx;
    #1;
    if (rst || dbus_rsp.ack) begin
      dbus_rsp.ack = 1'b0;
      d_busy       = 1'b0;
    end else if (dbus_req.cyc && dbus_req.stb) begin
      if (!d_busy) begin
        d_busy = 1'b1;
        d_held = dbus_req;
        draw_wait(d_wait);
      end else if (dbus_req !== d_held) begin
        $display("dbus request changed while waiting for ack");
        report_fail();
      end
      if (d_wait == 0) begin
        mem_index(dbus_req.adr, idx);
        if (dbus_req.we) mem[idx] = dbus_req.dat;
        else dbus_rsp.dat = mem[idx];
        dbus_rsp.ack = 1'b1;
        dbus_acks++;
      end else begin
        d_wait--;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic reset_core();
    next_cycle();
    rst = 1'b1;
    repeat (3) next_cycle();
    rst = 1'b0;
  endtask

  // instruction encoders
  function automatic inst_t enc_r(funct7_t f7, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                  reg_idx_t rd, opcode_e op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3, reg_idx_t rd,
                                  opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
  endfunction

  function automatic inst_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  task automatic emit(inst_t inst);
    prog.push_back(inst);
  endtask

  task automatic emit_li(reg_idx_t rd, word_t val);
    word_t hi;
    hi = (val + 32'h800) >> 12; // addi sign-extends the low part
    emit(enc_u(hi[19:0], rd, LUI));
    emit(enc_i(val[11:0], rd, F3_ADD, rd, OP_IMM));
  endtask

  task automatic emit_store(reg_idx_t rs, int k);
    emit(enc_s(12'(RES_OFS + 4 * k), rs, 5'd31));
  endtask

  task automatic emit_load(reg_idx_t rd, int k);
    emit(enc_i(12'(RES_OFS + 4 * k), 5'd31, 3'b010, rd, LOAD));
  endtask

  // x31 points at RESET_PC and stores are relative to it
  task automatic start_prog();
    prog.delete();
    emit(enc_u(20'h80000, 5'd31, LUI));
  endtask

  function automatic word_t result(int k);
    return mem[RES_OFS / 4 + k];
  endfunction

  function automatic logic result_flag(int k);
    return mem[RES_OFS / 4 + k][0];
  endfunction

  function automatic addr_t pc_of(int idx);
    return RESET_PC + addr_t'(4 * idx);
  endfunction

  task automatic run_prog(string name);
    int n;
    emit(EBREAK_INST);
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(pc_of(i));
    foreach (prog[i]) mem[i] = prog[i];
    dbus_acks = 0;
    reset_core();
    n = 0;
    while (!halted && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!halted) begin
      $display("%s: core did not halt within %0d cycles", name, TIMEOUT);
      report_fail();
    end
  endtask

  // RV32I reference semantics
  function automatic word_t alu_expect(funct3_t f3, bit alt, word_t a, word_t b);
    case (f3)
      F3_ADD:  return alt ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
      F3_SLTU: return {31'd0, a < b};
      F3_XOR:  return a ^ b;
      F3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_expect(funct3_t f3, word_t a, word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic test_alu_ops();
    word_t       a;
    word_t       b;
    funct3_t     f3_r [10];
    bit          alt_r [10];
    funct3_t     f3_i [9];
    bit          alt_i [9];
    logic [11:0] imm_i [9];
    a     = 32'hFFFF_FF9C; // -100
    b     = 32'h0000_0007;
    f3_r  = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
    alt_r = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    f3_i  = '{F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
    alt_i = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    imm_i = '{12'hFFB, 12'd4, 12'hF9D, 12'd5, 12'h555, 12'd4, 12'h404, 12'hF00, 12'h0F0};
    start_prog();
    emit_li(5'd1, a);
    emit_li(5'd2, b);
    for (int i = 0; i < 10; i++) begin
      emit(enc_r(alt_r[i] ? 7'b010_0000 : 7'b000_0000, 5'd2, 5'd1, f3_r[i], 5'd3, OP));
      emit_store(5'd3, i);
    end
    for (int i = 0; i < 9; i++) begin
      emit(enc_i(imm_i[i], 5'd1, f3_i[i], 5'd4, OP_IMM));
      emit_store(5'd4, 10 + i);
    end
    run_prog("alu_ops");
    for (int i = 0; i < 10; i++)
      check_word($sformatf("alu_ops reg %0d", i), alu_expect(f3_r[i], alt_r[i], a, b), result(i));
    for (int i = 0; i < 9; i++)
      check_word($sformatf("alu_ops imm %0d", i),
                 alu_expect(f3_i[i], alt_i[i], a, {{20{imm_i[i][11]}}, imm_i[i]}),
                 result(10 + i));
  endtask

  task automatic test_upper_imm();
    int at;
    start_prog();
    emit(enc_u(20'hABCDE, 5'd5, LUI));
    at = prog.size();
    emit(enc_u(20'h00012, 5'd6, AUIPC));
    emit_store(5'd5, 0);
    emit_store(5'd6, 1);
    run_prog("upper_imm");
    check_word("upper_imm lui", 32'hABCD_E000, result(0));
    check_addr("upper_imm auipc", pc_of(at) + 32'h0001_2000, result(1));
  endtask

  task automatic test_branches();
    funct3_t f3s [6];
    word_t   pa [3];
    word_t   pb [3];
    f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    pa  = '{32'd5, 32'hFFFF_FFFD, 32'd4}; // every branch sees both outcomes
    pb  = '{32'd5, 32'd4, 32'hFFFF_FFFD};
    start_prog();
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        emit_li(5'd1, pa[j]);
        emit_li(5'd2, pb[j]);
        emit(enc_i(12'd1, 5'd0, F3_ADD, 5'd7, OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, f3s[i])); // skips the clear below
        emit(enc_i(12'd0, 5'd0, F3_ADD, 5'd7, OP_IMM));
        emit_store(5'd7, 3 * i + j);
      end
    end
    run_prog("branches");
    for (int i = 0; i < 6; i++)
      for (int j = 0; j < 3; j++)
        check_flag($sformatf("branches f3=%0d pair %0d", f3s[i], j),
                   branch_expect(f3s[i], pa[j], pb[j]), result_flag(3 * i + j));
  endtask

  task automatic test_jumps();
    int    j0;
    int    jr;
    addr_t target;
    start_prog();
    emit(enc_i(12'd0, 5'd0, F3_ADD, 5'd8, OP_IMM)); // x8 marks a wrong path
    j0 = prog.size();
    emit(enc_j(21'd12, 5'd1));
    emit(enc_i(12'd1, 5'd0, F3_ADD, 5'd8, OP_IMM));
    emit(enc_i(12'd1, 5'd0, F3_ADD, 5'd8, OP_IMM));
    emit_store(5'd1, 0);
    emit_store(5'd8, 1);
    jr     = prog.size() + 2;
    target = pc_of(jr + 2);
    emit_li(5'd9, target - 32'd3); // +4 in jalr gives an odd sum
    emit(enc_i(12'd4, 5'd9, 3'b000, 5'd10, JALR));
    emit(enc_i(12'd1, 5'd0, F3_ADD, 5'd8, OP_IMM));
    emit_store(5'd10, 2);
    emit_store(5'd8, 3);
    run_prog("jumps");
    check_addr("jumps jal link", pc_of(j0) + 32'd4, result(0));
    check_flag("jumps jal skipped", 1'b0, result_flag(1));
    check_addr("jumps jalr link", pc_of(jr) + 32'd4, result(2));
    check_flag("jumps jalr skipped", 1'b0, result_flag(3));
  endtask

  task automatic test_load_store();
    start_prog();
    emit_li(5'd11, 32'h1234_5678);
    emit_store(5'd11, 0);
    emit_load(5'd12, 0);
    emit_store(5'd12, 1);
    emit_li(5'd11, 32'hC0DE_F00D);
    emit_store(5'd11, 2);
    emit_load(5'd13, 5); // untouched word that still holds the fill
    emit_store(5'd13, 6);
    run_prog("load_store");
    check_word("load_store first", 32'h1234_5678, result(0));
    check_word("load_store copy", 32'h1234_5678, result(1));
    check_word("load_store second", 32'hC0DE_F00D, result(2));
    check_word("load_store fill", fill_word(pc_of(RES_OFS / 4 + 5)), result(6));
    check_word("load_store dbus cycles", 32'd6, word_t'(dbus_acks));
  endtask

  task automatic test_halt();
    start_prog();
    emit_li(5'd14, 32'h55);
    emit(EBREAK_INST);
    emit_store(5'd14, 0); // must never run
    run_prog("halt");
    for (int n = 0; n < 50; n++) begin
      check_flag("halt ibus cyc", 1'b0, ibus_req.cyc);
      check_flag("halt ibus stb", 1'b0, ibus_req.stb);
      check_flag("halt halted", 1'b1, halted);
      next_cycle();
    end
    check_word("halt no store", fill_word(pc_of(RES_OFS / 4)), result(0));
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    ibus_rsp  = '0;
    dbus_rsp  = '0;
    lfsr      = 32'h931e;
    i_busy    = 1'b0;
    d_busy    = 1'b0;
    i_wait    = 0;
    d_wait    = 0;
    d_held    = '0;
    dbus_acks = 0;
    test_alu_ops();
    test_upper_imm();
    test_branches();
    test_jumps();
    test_load_store();
    test_halt();
    $display("** PASS **");
    $finish;
  end

endmodule
